//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // ----------------------------------------------------------
    // Base widths
    // ----------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int REG_INDEX_W = 5;

    // ----------------------------------------------------------
    // Major opcodes handled by the core
    // ----------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7, picks SUB over ADD and SRA over SRL
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // One instruction word, viewed as R form or as I form
    // U immediate comes from the upper 20 bits of the I view
    typedef union packed
    {
        struct packed
        {
            logic [6:0]             funct7;
            logic [REG_INDEX_W-1:0] rs2;
            logic [REG_INDEX_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [REG_INDEX_W-1:0] rd;
            logic [6:0]             opcode;
        } r;
        struct packed
        {
            logic [11:0]            imm12;
            logic [REG_INDEX_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [REG_INDEX_W-1:0] rd;
            logic [6:0]             opcode;
        } i;
    } rv_instr_u;

endpackage

`default_nettype wire

//--- source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    // ----------------------------------------------------------
    // ALU operation codes
    // ----------------------------------------------------------
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    // Second input straight through, used by LUI
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    // Source operands per instruction, one forwarding unit each
    localparam int NUM_SOURCES = 2;

endpackage

`default_nettype wire

//--- source/rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  wire                                     CLK,
    input  wire                                     reset,
    input  wire                                     advance,
    input  wire                                     instr_valid,
    input  wire [XLEN-1:0]                          instr_data,
    output logic [NUM_SOURCES-1:0][REG_INDEX_W-1:0] src_index,
    output logic                                    d_valid,
    output logic                                    d_write,
    output logic [REG_INDEX_W-1:0]                  d_rd,
    output logic [ALU_OP_W-1:0]                     d_alu_op,
    output logic [XLEN-1:0]                         d_imm,
    output logic                                    d_use_imm
);

    rv_instr_u       instr_q;
    logic            known;
    logic            shift_alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;

    // Shared funct3 map for OP and OP-IMM
    function automatic logic [ALU_OP_W-1:0] alu_from_funct3(input logic [2:0] f3,
                                                            input logic       alt);
        logic [ALU_OP_W-1:0] op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    // ----------------------------------------------------------
    // Decode register
    // ----------------------------------------------------------
    // Empty slot when nothing was accepted, so a bubble moves on
    always_ff @(posedge CLK)
    begin
        if (reset)
            d_valid <= 1'b0;
        else if (advance)
            d_valid <= instr_valid;
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
            instr_q <= instr_data;
    end

    // ----------------------------------------------------------
    // Field decode
    // ----------------------------------------------------------
    // Register indices go out every cycle, the execute stage ignores rs2 for I form
    assign src_index[0] = instr_q.r.rs1;
    assign src_index[1] = instr_q.r.rs2;
    assign d_rd         = instr_q.r.rd;

    // Sign-extended I immediate
    assign imm_i = {{(XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
    // U immediate, low 12 bits zero
    assign imm_u = {instr_q.i.imm12, instr_q.i.rs1, instr_q.i.funct3, 12'b0};

    // Immediate form has no SUB, only right shifts look at the top bits
    assign shift_alt = (instr_q.i.funct3 == F3_SRL_SRA) && (instr_q.r.funct7 == F7_ALT);

    always_comb
    begin
        known     = 1'b1;
        d_alu_op  = ALU_ADD;
        d_imm     = imm_i;
        d_use_imm = 1'b1;
        case (instr_q.r.opcode)
            OPC_OP:
            begin
                d_use_imm = 1'b0;
                d_alu_op  = alu_from_funct3(instr_q.r.funct3, instr_q.r.funct7 == F7_ALT);
            end
            OPC_OP_IMM:
            begin
                d_alu_op = alu_from_funct3(instr_q.i.funct3, shift_alt);
            end
            OPC_LUI:
            begin
                d_alu_op = ALU_PASS_B;
                d_imm    = imm_u;
            end
            default:
            begin
                // Retires without a register write
                known = 1'b0;
            end
        endcase
    end

    // No write for bubbles, unknown opcodes or x0
    assign d_write = d_valid && known && (instr_q.r.rd != '0);

endmodule

`default_nettype wire

//--- source/rv_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_register_file
    import rv_isa_pkg::*, rv_pipe_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  wire                                     CLK,
    input  wire                                     reset,
    input  wire [NUM_SOURCES-1:0][REG_INDEX_W-1:0]  src_index,
    input  wire                                     write_enable,
    input  wire [REG_INDEX_W-1:0]                   write_index,
    input  wire [XLEN-1:0]                          write_data,
    output logic [NUM_SOURCES-1:0][XLEN-1:0]        rf_data
);

    // Array index width, 5 for RV32I and 4 for RV32E
    localparam int IDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Synchronous clear, then single write port
    // x0 and indices past the array are dropped
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int n = 0; n < NUM_REGS; n++)
                regs[n] <= '0;
        end
        else if (write_enable && (write_index != '0) && (write_index < NUM_REGS))
            regs[write_index[IDX_W-1:0]] <= write_data;
    end

    // Combinational reads, zero for x0 and out-of-range indices
    always_comb
    begin
        for (int s = 0; s < NUM_SOURCES; s++)
        begin
            if ((src_index[s] == '0) || (src_index[s] >= NUM_REGS))
                rf_data[s] = '0;
            else
                rf_data[s] = regs[src_index[s][IDX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- source/rv_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_forward_unit
    import rv_isa_pkg::*;
(
    input  wire [REG_INDEX_W-1:0] src_index_in,
    input  wire [XLEN-1:0]        rf_value,
    input  wire                   e_write,
    input  wire [REG_INDEX_W-1:0] e_rd,
    input  wire [XLEN-1:0]        e_result,
    input  wire                   w_write,
    input  wire [REG_INDEX_W-1:0] w_rd,
    input  wire [XLEN-1:0]        w_data,
    output logic [XLEN-1:0]       operand
);

    logic hit_e;
    logic hit_w;

    // x0 always comes from the register file, which reads zero
    assign hit_e = e_write && (e_rd == src_index_in) && (src_index_in != '0);
    assign hit_w = w_write && (w_rd == src_index_in) && (src_index_in != '0);

    // Youngest producer first
    always_comb
    begin
        if (hit_e)
            operand = e_result;
        else if (hit_w)
            operand = w_data;
        else
            operand = rf_value;
    end

endmodule

`default_nettype wire

//--- source/rv_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  wire                                 CLK,
    input  wire                                 reset,
    input  wire                                 advance,
    input  wire                                 d_valid,
    input  wire                                 d_write,
    input  wire [REG_INDEX_W-1:0]               d_rd,
    input  wire [ALU_OP_W-1:0]                  d_alu_op,
    input  wire [XLEN-1:0]                      d_imm,
    input  wire                                 d_use_imm,
    input  wire [NUM_SOURCES-1:0][XLEN-1:0]     operand,
    output logic                                e_write,
    output logic [REG_INDEX_W-1:0]              e_rd,
    output logic [XLEN-1:0]                     e_result,
    output logic                                e_valid
);

    logic                             write_q;
    logic [ALU_OP_W-1:0]              alu_op_q;
    logic [XLEN-1:0]                  imm_q;
    logic                             use_imm_q;
    logic [NUM_SOURCES-1:0][XLEN-1:0] src_q;
    logic [XLEN-1:0]                  alu_a;
    logic [XLEN-1:0]                  alu_b;
    logic [4:0]                       shamt;

    // ----------------------------------------------------------
    // Execute register
    // ----------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            e_valid <= 1'b0;
            write_q <= 1'b0;
        end
        else if (advance)
        begin
            e_valid <= d_valid;
            write_q <= d_write;
        end
    end

    // Fields and forwarded operands
    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            e_rd      <= d_rd;
            alu_op_q  <= d_alu_op;
            imm_q     <= d_imm;
            use_imm_q <= d_use_imm;
            src_q     <= operand;
        end
    end

    assign e_write = e_valid && write_q;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    assign alu_a = src_q[0];
    assign alu_b = use_imm_q ? imm_q : src_q[1];
    // Shift amount from low five bits only
    assign shamt = alu_b[4:0];

    always_comb
    begin
        case (alu_op_q)
            ALU_ADD:    e_result = alu_a + alu_b;
            ALU_SUB:    e_result = alu_a - alu_b;
            ALU_SLL:    e_result = alu_a << shamt;
            ALU_SLT:    e_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   e_result = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:    e_result = alu_a ^ alu_b;
            ALU_SRL:    e_result = alu_a >> shamt;
            ALU_SRA:    e_result = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:     e_result = alu_a | alu_b;
            ALU_AND:    e_result = alu_a & alu_b;
            ALU_PASS_B: e_result = alu_b;
            default:    e_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv_writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback_stage
    import rv_isa_pkg::*;
(
    input  wire                     CLK,
    input  wire                     reset,
    input  wire                     e_valid,
    input  wire                     e_write,
    input  wire [REG_INDEX_W-1:0]   e_rd,
    input  wire [XLEN-1:0]          e_result,
    input  wire                     retire_ready,
    output logic                    advance,
    output logic                    retire_valid,
    output logic                    retire_write,
    output logic [REG_INDEX_W-1:0]  retire_index,
    output logic [XLEN-1:0]         retire_data,
    output logic                    rf_write_enable
);

    logic retire_fire;

    // ----------------------------------------------------------
    // Global advance
    // ----------------------------------------------------------
    // Slot empty or draining this edge, so every stage may move
    assign advance     = !retire_valid || retire_ready;
    assign retire_fire = retire_valid && retire_ready;

    // Writeback register, held as the retire payload
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            retire_valid <= 1'b0;
            retire_write <= 1'b0;
        end
        else if (advance)
        begin
            retire_valid <= e_valid;
            retire_write <= e_write;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            retire_index <= e_rd;
            retire_data  <= e_result;
        end
    end

    // Register write lands on the retire transfer edge
    assign rf_write_enable = retire_fire && retire_write;

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
    import rv_isa_pkg::*, rv_pipe_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  wire                     CLK,
    input  wire                     reset,
    // Instruction stream
    input  wire                     instr_valid,
    input  wire [XLEN-1:0]          instr_data,
    output logic                    instr_ready,
    // Retire stream
    output logic                    retire_valid,
    output logic                    retire_write,
    output logic [REG_INDEX_W-1:0]  retire_index,
    output logic [XLEN-1:0]         retire_data,
    input  wire                     retire_ready
);

    wire                                    advance;
    wire [NUM_SOURCES-1:0][REG_INDEX_W-1:0] src_index;
    wire [NUM_SOURCES-1:0][XLEN-1:0]        rf_data;
    wire [NUM_SOURCES-1:0][XLEN-1:0]        operand;

    // Decode to execute
    wire                    d_valid;
    wire                    d_write;
    wire [REG_INDEX_W-1:0]  d_rd;
    wire [ALU_OP_W-1:0]     d_alu_op;
    wire [XLEN-1:0]         d_imm;
    wire                    d_use_imm;

    // Execute to writeback and forwarding
    wire                    e_valid;
    wire                    e_write;
    wire [REG_INDEX_W-1:0]  e_rd;
    wire [XLEN-1:0]         e_result;
    wire                    rf_write_enable;

    // Accept only when the whole pipe moves
    assign instr_ready = advance;

    // ----------------------------------------------------------
    // Stages
    // ----------------------------------------------------------
    rv_decode_stage decode_stage
    (
        .CLK         (CLK),
        .reset       (reset),
        .advance     (advance),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .src_index   (src_index),
        .d_valid     (d_valid),
        .d_write     (d_write),
        .d_rd        (d_rd),
        .d_alu_op    (d_alu_op),
        .d_imm       (d_imm),
        .d_use_imm   (d_use_imm)
    );

    rv_register_file
    #(
        .NUM_REGS (NUM_REGS)
    )
    register_file
    (
        .CLK          (CLK),
        .reset        (reset),
        .src_index    (src_index),
        .write_enable (rf_write_enable),
        .write_index  (retire_index),
        .write_data   (retire_data),
        .rf_data      (rf_data)
    );

    // One forwarding unit per source operand
    // Writeback slot forwards until its transfer edge
    for (genvar g = 0; g < NUM_SOURCES; g++)
    begin : g_forward
        rv_forward_unit forward_unit
        (
            .src_index_in (src_index[g]),
            .rf_value     (rf_data[g]),
            .e_write      (e_write),
            .e_rd         (e_rd),
            .e_result     (e_result),
            .w_write      (retire_write),
            .w_rd         (retire_index),
            .w_data       (retire_data),
            .operand      (operand[g])
        );
    end

    rv_execute_stage execute_stage
    (
        .CLK       (CLK),
        .reset     (reset),
        .advance   (advance),
        .d_valid   (d_valid),
        .d_write   (d_write),
        .d_rd      (d_rd),
        .d_alu_op  (d_alu_op),
        .d_imm     (d_imm),
        .d_use_imm (d_use_imm),
        .operand   (operand),
        .e_write   (e_write),
        .e_rd      (e_rd),
        .e_result  (e_result),
        .e_valid   (e_valid)
    );

    rv_writeback_stage writeback_stage
    (
        .CLK             (CLK),
        .reset           (reset),
        .e_valid         (e_valid),
        .e_write         (e_write),
        .e_rd            (e_rd),
        .e_result        (e_result),
        .retire_ready    (retire_ready),
        .advance         (advance),
        .retire_valid    (retire_valid),
        .retire_write    (retire_write),
        .retire_index    (retire_index),
        .retire_data     (retire_data),
        .rf_write_enable (rf_write_enable)
    );

endmodule

`default_nettype wire

//--- verif/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props
    import rv_isa_pkg::*;
(
    input wire                   CLK,
    input wire                   reset,
    input wire                   instr_ready,
    input wire                   retire_valid,
    input wire                   retire_write,
    input wire [REG_INDEX_W-1:0] retire_index,
    input wire [XLEN-1:0]        retire_data,
    input wire                   retire_ready
);

    // Nothing retires while the pipe is held in reset
    retire_idle_in_reset: assert property (@(posedge CLK) reset |=> !retire_valid)
        else $error("retire_valid high after a reset edge");

    // Offered retirement stays put until taken
    retire_payload_held: assert property (@(posedge CLK) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_write)
            && $stable(retire_index) && $stable(retire_data))
        else $error("retire payload changed under back-pressure");

    // Input side accepts exactly when the writeback slot can move
    ready_follows_advance: assert property (@(posedge CLK) disable iff (reset)
        instr_ready == (!retire_valid || retire_ready))
        else $error("instr_ready differs from the advance rule");

endmodule

bind rv_core_top rv_core_props props_check
(
    .CLK          (CLK),
    .reset        (reset),
    .instr_ready  (instr_ready),
    .retire_valid (retire_valid),
    .retire_write (retire_write),
    .retire_index (retire_index),
    .retire_data  (retire_data),
    .retire_ready (retire_ready)
);

`default_nettype wire

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_isa_pkg::*;
();

    localparam logic [31:0] SEED           = 32'd64220;
    localparam int          NUM_INSTR      = 2000;
    localparam int          RESET_CYCLES   = 16;
    localparam int          ACCEPT_TIMEOUT = 100;
    localparam int          DRAIN_TIMEOUT  = 500;

    // Expected retirement entry
    // Data is compared only when the opcode is one the core executes
    typedef struct packed
    {
        logic                   write;
        logic                   known;
        logic [REG_INDEX_W-1:0] index;
        logic [XLEN-1:0]        data;
    } retire_t;

    logic                   CLK;
    logic                   reset;
    logic                   instr_valid;
    logic [XLEN-1:0]        instr_data;
    wire                    instr_ready;
    wire                    retire_valid;
    wire                    retire_write;
    wire [REG_INDEX_W-1:0]  retire_index;
    wire [XLEN-1:0]         retire_data;
    logic                   retire_ready;

    // Architectural model and the queue of expected retirements
    logic [XLEN-1:0] model_regs [32];
    retire_t         expected_q [$];
    logic [31:0]     stim_state;
    int              retire_count;

    rv_core_top
    #(
        .NUM_REGS (32)
    )
    DUT
    (
        .CLK          (CLK),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .instr_ready  (instr_ready),
        .retire_valid (retire_valid),
        .retire_write (retire_write),
        .retire_index (retire_index),
        .retire_data  (retire_data),
        .retire_ready (retire_ready)
    );

    // 10 ns clock
    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    // ----------------------------------------------------------
    // Reporting
    // ----------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("mismatch at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
    endtask

    // ----------------------------------------------------------
    // Random stimulus
    // ----------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Small pool keeps dependencies dense
    // x0 shows up now and then as source and destination
    function automatic logic [REG_INDEX_W-1:0] pick_register(input logic [2:0] sel);
        logic [REG_INDEX_W-1:0] idx;
        case (sel)
            3'd0:    idx = 5'd0;
            3'd1,
            3'd2:    idx = 5'd1;
            3'd3:    idx = 5'd2;
            3'd4:    idx = 5'd3;
            3'd5:    idx = 5'd4;
            default: idx = 5'd31;
        endcase
        return idx;
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [31:0]            r1;
        logic [31:0]            r2;
        logic [REG_INDEX_W-1:0] rd;
        logic [REG_INDEX_W-1:0] rs1;
        logic [REG_INDEX_W-1:0] rs2;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [11:0]            imm;
        logic [6:0]             opc;
        logic [31:0]            word;
        stim_state = xorshift32(stim_state);
        r1         = stim_state;
        stim_state = xorshift32(stim_state);
        r2         = stim_state;
        rd         = pick_register(r1[6:4]);
        rs1        = pick_register(r1[9:7]);
        rs2        = pick_register(r1[12:10]);
        f3         = r1[15:13];
        // Alternate funct7 only where the ISA defines one
        f7 = (r1[16] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : 7'b0;
        if (r1[3:0] < 4'd7)
            word = {f7, rs2, rs1, f3, rd, OPC_OP};
        else if (r1[3:0] < 4'd13)
        begin
            imm = r2[11:0];
            // Shift immediates carry a 5-bit amount plus the SRAI marker
            if (f3 == F3_SLL)
                imm = {7'b0, r2[4:0]};
            else if (f3 == F3_SRL_SRA)
                imm = {f7, r2[4:0]};
            word = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        else if (r1[3:0] < 4'd15)
            word = {r2[31:12], rd, OPC_LUI};
        else
        begin
            // Load, store, branch or AUIPC
            case (r2[1:0])
                2'd0:    opc = 7'b0000011;
                2'd1:    opc = 7'b0100011;
                2'd2:    opc = 7'b1100011;
                default: opc = 7'b0010111;
            endcase
            word = {r2[31:12], rd, opc};
        end
        return word;
    endfunction

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic retire_t reference_result(input logic [31:0] word);
        retire_t     r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fill;
        logic [4:0]  sh;
        logic        alt;
        a       = model_regs[word[19:15]];
        r.index = word[11:7];
        r.known = 1'b1;
        r.data  = '0;
        // Second input is rs2 for OP, otherwise the sign-extended I immediate
        if (word[6:0] == OPC_OP)
            b = model_regs[word[24:20]];
        else
            b = {{20{word[31]}}, word[31:20]};
        sh = b[4:0];
        // funct7 0100000 means SUB or SRA, and SRAI among the immediates
        alt = (word[31:25] == F7_ALT) &&
              ((word[6:0] == OPC_OP) || (word[14:12] == F3_SRL_SRA));
        // Sign bits shifted in from the top for SRA
        fill = (alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
        if (word[6:0] == OPC_LUI)
            r.data = {word[31:12], 12'b0};
        else if ((word[6:0] == OPC_OP) || (word[6:0] == OPC_OP_IMM))
        begin
            case (word[14:12])
                F3_ADD_SUB: r.data = alt ? a - b : a + b;
                F3_SLL:     r.data = a << sh;
                // Differing signs decide by the sign of a
                F3_SLT:     r.data = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                F3_SLTU:    r.data = {31'b0, a < b};
                F3_XOR:     r.data = a ^ b;
                F3_SRL_SRA: r.data = (a >> sh) | fill;
                F3_OR:      r.data = a | b;
                default:    r.data = a & b;
            endcase
        end
        else
            r.known = 1'b0;
        r.write = r.known && (r.index != 5'd0);
        return r;
    endfunction

    // Model follows acceptance order, which is program order
    task automatic accept_instruction(input logic [31:0] word);
        retire_t r;
        r = reference_result(word);
        if (r.write)
            model_regs[r.index] = r.data;
        expected_q.push_back(r);
    endtask

    // Holds valid and payload until the transfer edge
    task automatic send_instruction(input logic [31:0] word);
        int   waited;
        logic accepted;
        instr_valid = 1'b1;
        instr_data  = word;
        waited      = 0;
        accepted    = 1'b0;
        while (!accepted)
        begin
            if (waited == ACCEPT_TIMEOUT)
                fail_run("timeout: instruction not accepted while instr_valid was held");
            waited++;
            // Inputs settle 1 ns after the edge, so mid-cycle ready is ready at the edge
            @(negedge CLK);
            accepted = instr_ready;
            if (accepted)
                accept_instruction(word);
            @(posedge CLK);
            #1;
        end
        instr_valid = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Retire back-pressure
    // ----------------------------------------------------------
    initial
    begin
        logic [31:0] ready_state;
        // Separate stream derived from the same seed
        ready_state  = ~SEED;
        retire_ready = 1'b0;
        forever
        begin
            @(posedge CLK);
            #1;
            ready_state  = xorshift32(ready_state);
            // Low about a quarter of the time
            retire_ready = !reset && (ready_state[1:0] != 2'b00);
        end
    end

    // ----------------------------------------------------------
    // Retire checker
    // ----------------------------------------------------------
    initial
    begin
        retire_t                entry;
        logic                   held;
        logic                   held_write;
        logic [REG_INDEX_W-1:0] held_index;
        logic [XLEN-1:0]        held_data;
        retire_count = 0;
        held         = 1'b0;
        forever
        begin
            @(negedge CLK);
            if (reset)
                held = 1'b0;
            else
            begin
                // A stalled retirement keeps its payload
                if (held)
                begin
                    check_value("retire_valid", 32'(retire_valid), 32'd1);
                    check_value("retire_write", 32'(retire_write), 32'(held_write));
                    check_value("retire_index", 32'(retire_index), 32'(held_index));
                    check_value("retire_data", retire_data, held_data);
                end
                // Whole pipe freezes while a retirement waits
                check_value("instr_ready", 32'(instr_ready),
                            32'(!retire_valid || retire_ready));
                if (retire_valid && retire_ready)
                begin
                    if (expected_q.size() == 0)
                        fail_run("retirement seen with no accepted instruction outstanding");
                    entry = expected_q.pop_front();
                    check_value("retire_write", 32'(retire_write), 32'(entry.write));
                    check_value("retire_index", 32'(retire_index), 32'(entry.index));
                    if (entry.known)
                        check_value("retire_data", retire_data, entry.data);
                    retire_count++;
                end
                held       = retire_valid && !retire_ready;
                held_write = retire_write;
                held_index = retire_index;
                held_data  = retire_data;
            end
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial
    begin
        int waited;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        stim_state  = SEED;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_data  = '0;

        // Outputs idle and ready while in reset
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge CLK);
            @(negedge CLK);
            check_value("retire_valid", 32'(retire_valid), 32'd0);
            check_value("instr_ready", 32'(instr_ready), 32'd1);
        end
        @(posedge CLK);
        #1;
        reset = 1'b0;

        // First cycle out of reset
        @(negedge CLK);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("instr_ready", 32'(instr_ready), 32'd1);
        @(posedge CLK);
        #1;

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            stim_state = xorshift32(stim_state);
            // Occasional idle gap of one to four cycles
            if (stim_state[3:0] == 4'd0)
            begin
                repeat (1 + stim_state[5:4])
                begin
                    @(posedge CLK);
                    #1;
                end
            end
            send_instruction(random_instruction());
        end

        // Drain the pipe
        waited = 0;
        while (retire_count < NUM_INSTR)
        begin
            if (waited == DRAIN_TIMEOUT)
                fail_run("timeout: not every accepted instruction retired");
            waited++;
            @(posedge CLK);
        end

        if (expected_q.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
            fail_run("expected retirements still queued after the last retirement");
    end

endmodule

`default_nettype wire

//--- src.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_decode_stage.sv
source/rv_register_file.sv
source/rv_forward_unit.sv
source/rv_execute_stage.sv
source/rv_writeback_stage.sv
source/rv_core_top.sv
verif/rv_core_props.sv
verif/tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Simulator binary, rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard source/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f

# Pass or fail comes from the log
run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
